//--- Makefile
# Verilator build and run of the fetch-stage testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_if_stage
FILELIST ?= compile.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
source/if_pkg.sv
source/fetch_if.sv
source/pc_select.sv
source/prefetch_unit.sv
source/if_id_reg.sv
source/if_stage.sv
test/clk_rst_gen.sv
test/if_stage_assert.sv
test/tb_if_stage.sv

//--- source/fetch_if.sv
// fetch handshake between the prefetch buffer and the IF-ID register
`timescale 1ns/1ps

interface fetch_if;

  // word offered by the prefetch buffer
  logic          valid;
  if_pkg::word_t rdata;
  if_pkg::addr_t addr;
  // bus error flag of this word
  logic          err;
  // IF-ID register can take the word
  logic          ready;

  // prefetch side
  modport src (output valid, rdata, addr, err, input ready);

  // pipeline register side
  modport dst (input valid, rdata, addr, err, output ready);

endinterface

//--- source/if_id_reg.sv
// IF-ID pipeline register
// valid, new-instruction pulse and combined fetch error
`timescale 1ns/1ps

module if_id_reg (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          id_in_ready_i,
  input  logic          instr_valid_clear_i,
  input  logic          pmp_err_if_i,
  output logic          instr_valid_id_o,
  output logic          instr_new_id_o,
  output if_pkg::word_t instr_rdata_id_o,
  output if_pkg::addr_t pc_id_o,
  output if_pkg::addr_t pc_if_o,
  output logic          instr_fetch_err_o,
  fetch_if.dst          fetch_i
);

  logic hs;
  logic valid_q, new_q;

  // ID takes a word whenever it is ready
  assign fetch_i.ready = id_in_ready_i;
  assign hs            = fetch_i.valid & fetch_i.ready;

  // address of the word currently offered, pmp checks against this
  assign pc_if_o = fetch_i.addr;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      // valid holds until the ID stage clears it
      valid_q <= hs | (valid_q & ~instr_valid_clear_i);
      new_q   <= hs;
    end
  end

  // payload, frozen while stalled
  always_ff @(posedge clk_i) begin
    if (hs) begin
      instr_rdata_id_o  <= fetch_i.rdata;
      pc_id_o           <= fetch_i.addr;
      // bus error or pmp fault on this word
      instr_fetch_err_o <= fetch_i.err | pmp_err_if_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

//--- source/if_pkg.sv
// fetch-stage types and constants
// next-pc and exception handler select enums
package if_pkg;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // interrupt cause index for vectored mode
  typedef logic [4:0] irq_vec_t;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of handler entered on PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////
  // constants
  ////////////////////

  // debug module entry points
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam addr_t DM_EXC_ADDR  = 32'h1A11_0808;

  // first instruction sits 0x80 into the aligned boot region
  localparam logic [7:0] BOOT_OFFSET     = 8'h80;
  localparam int unsigned TVEC_ALIGN_BITS = 8;
  // all internal interrupts share this vector
  localparam irq_vec_t NMI_VEC = 5'd31;

  localparam int unsigned PREFETCH_DEPTH = 2;
  localparam addr_t INSTR_BYTES = 32'd4;

endpackage

//--- source/if_stage.sv
// instruction fetch stage top
// pc select, prefetch unit and IF-ID register
`timescale 1ns/1ps

module if_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  if_pkg::addr_t       boot_addr_i,
  input  logic                req_i,
  // wishbone instruction bus
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output if_pkg::addr_t       wb_adr_o,
  input  if_pkg::word_t       wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  // to ID
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::word_t       instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_if_o,
  output if_pkg::addr_t       pc_id_o,
  input  logic                pmp_err_if_i,
  // control
  input  logic                instr_valid_clear_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_vec_t    irq_vec_i,
  input  logic                irq_int_i,
  input  if_pkg::addr_t       branch_target_i,
  // csr
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  output logic                csr_mtvec_init_o,
  input  logic                id_in_ready_i,
  output logic                if_busy_o
);

  if_pkg::addr_t fetch_addr_n;

  fetch_if fetch_bus ();

  pc_select pc_select_i (
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_vec_i       (irq_vec_i),
    .irq_int_i       (irq_int_i),
    .pc_set_i        (pc_set_i),
    .fetch_addr_o    (fetch_addr_n),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  // redirect reaches the prefetcher in the same cycle
  prefetch_unit prefetch_unit_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .branch_i     (pc_set_i),
    .branch_addr_i(fetch_addr_n),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i),
    .busy_o       (if_busy_o),
    .fetch_o      (fetch_bus.src)
  );

  if_id_reg if_id_reg_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .pmp_err_if_i       (pmp_err_if_i),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .pc_id_o            (pc_id_o),
    .pc_if_o            (pc_if_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .fetch_i            (fetch_bus.dst)
  );

endmodule

//--- source/pc_select.sv
// next fetch address mux and exception handler address
// also flags mtvec init on boot
`timescale 1ns/1ps

module pc_select (
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_vec_t    irq_vec_i,
  input  logic                irq_int_i,
  input  logic                pc_set_i,
  output if_pkg::addr_t       fetch_addr_o,
  output logic                csr_mtvec_init_o
);

  if_pkg::addr_t    trap_base;
  if_pkg::addr_t    boot_pc;
  if_pkg::addr_t    exc_pc;
  if_pkg::irq_vec_t irq_vec;

  // low bits of mtvec hold the mode field, drop them
  assign trap_base = {csr_mtvec_i[31:if_pkg::TVEC_ALIGN_BITS], {if_pkg::TVEC_ALIGN_BITS{1'b0}}};
  assign boot_pc   = {boot_addr_i[31:if_pkg::TVEC_ALIGN_BITS], if_pkg::BOOT_OFFSET};

  // internal interrupts always take the nmi slot
  assign irq_vec = irq_int_i ? if_pkg::NMI_VEC : irq_vec_i;

  // handler address
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = trap_base;
      if_pkg::EXC_PC_IRQ:     exc_pc = trap_base + if_pkg::addr_t'(irq_vec) * if_pkg::INSTR_BYTES;
      if_pkg::EXC_PC_DBD:     exc_pc = if_pkg::DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = if_pkg::DM_EXC_ADDR;
      default:                exc_pc = trap_base;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: fetch_addr_o = boot_pc;
      if_pkg::PC_JUMP: fetch_addr_o = branch_target_i;
      if_pkg::PC_EXC:  fetch_addr_o = exc_pc;
      if_pkg::PC_ERET: fetch_addr_o = csr_mepc_i;
      if_pkg::PC_DRET: fetch_addr_o = csr_depc_i;
      default:         fetch_addr_o = boot_pc;
    endcase
  end

  // csr file loads mtvec from boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

//--- source/prefetch_unit.sv
// wishbone classic read master feeding a small prefetch buffer
// branch flushes the buffer and drops the open response
`timescale 1ns/1ps

module prefetch_unit (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  input  logic          branch_i,
  input  if_pkg::addr_t branch_addr_i,
  output logic          wb_cyc_o,
  output logic          wb_stb_o,
  output if_pkg::addr_t wb_adr_o,
  input  if_pkg::word_t wb_dat_i,
  input  logic          wb_ack_i,
  input  logic          wb_err_i,
  output logic          busy_o,
  fetch_if.src          fetch_o
);

  // bus cycle state
  logic          cyc_q;
  logic          discard_q;
  if_pkg::addr_t adr_q;
  if_pkg::addr_t fetch_addr_q;

  // buffer storage, payload only
  if_pkg::word_t pb_rdata_q [if_pkg::PREFETCH_DEPTH];
  if_pkg::addr_t pb_addr_q  [if_pkg::PREFETCH_DEPTH];
  logic          pb_err_q   [if_pkg::PREFETCH_DEPTH];

  logic [$clog2(if_pkg::PREFETCH_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(if_pkg::PREFETCH_DEPTH+1)-1:0] count_q, count_next;

  logic          resp, push, pop, start;
  if_pkg::addr_t branch_addr, start_addr;

  ////////////////////
  // control
  ////////////////////

  // only whole words are fetched
  assign branch_addr = branch_addr_i & ~(if_pkg::INSTR_BYTES - 32'd1);

  assign resp = cyc_q & (wb_ack_i | wb_err_i);
  // response of a cycle opened before a branch goes nowhere
  assign push = resp & ~discard_q & ~branch_i;
  assign pop  = fetch_o.valid & fetch_o.ready;

  always_comb begin
    count_next = count_q;
    if (push) begin
      count_next = count_next + 1'b1;
    end
    if (pop) begin
      count_next = count_next - 1'b1;
    end
    if (branch_i) begin
      count_next = '0;
    end
  end

  // new read only when no cycle stays open and a slot is free for it
  assign start      = req_i & (~cyc_q | resp) & (count_next < if_pkg::PREFETCH_DEPTH);
  assign start_addr = branch_i ? branch_addr : fetch_addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q        <= 1'b0;
      discard_q    <= 1'b0;
      adr_q        <= '0;
      fetch_addr_q <= '0;
      count_q      <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      count_q <= count_next;
      // cyc and stb drop after ack/err unless the next read follows at once
      if (start) begin
        cyc_q        <= 1'b1;
        adr_q        <= start_addr;
        fetch_addr_q <= start_addr + if_pkg::INSTR_BYTES;
      end else begin
        if (resp) begin
          cyc_q <= 1'b0;
        end
        if (branch_i) begin
          fetch_addr_q <= branch_addr;
        end
      end
      // branch mid-cycle marks the open read as stale
      if (resp) begin
        discard_q <= 1'b0;
      end else if (branch_i && cyc_q) begin
        discard_q <= 1'b1;
      end
      if (branch_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (int'(wr_ptr_q) == if_pkg::PREFETCH_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (int'(rd_ptr_q) == if_pkg::PREFETCH_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // buffer
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      pb_rdata_q[wr_ptr_q] <= wb_dat_i;
      pb_addr_q[wr_ptr_q]  <= adr_q;
      pb_err_q[wr_ptr_q]   <= wb_err_i;
    end
  end

  // head of the buffer, hidden during a redirect
  assign fetch_o.valid = (count_q != '0) & ~branch_i;
  assign fetch_o.rdata = pb_rdata_q[rd_ptr_q];
  assign fetch_o.addr  = pb_addr_q[rd_ptr_q];
  assign fetch_o.err   = pb_err_q[rd_ptr_q];

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;
  assign busy_o   = cyc_q | (count_q != '0);

endmodule

//--- test/clk_rst_gen.sv
// testbench clock and reset source
// 100 ns period, reset low for the first 5 cycles
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release away from the clock edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

//--- test/if_stage_assert.sv
// wishbone handshake and fetch handshake properties
// bound into the prefetch unit
`timescale 1ns/1ps

module if_stage_assert (
  input logic          clk_i,
  input logic          rst_ni,
  input logic          cyc_i,
  input logic          stb_i,
  input if_pkg::addr_t adr_i,
  input logic          ack_i,
  input logic          err_i,
  input logic          branch_i,
  input logic          valid_i
);

  // a slave response only comes inside an open strobe
  resp_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i || err_i) |-> (cyc_i && stb_i))
    else $error("wishbone ack or err outside an open cycle");

  // open cycle keeps its address until ack or err
  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cyc_i && !(ack_i || err_i)) |=> (cyc_i && $stable(adr_i)))
    else $error("wishbone cycle dropped or address moved before ack");

  // word fetches only
  adr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cyc_i |-> (adr_i[1:0] == 2'b00))
    else $error("wishbone address not word aligned");

  // redirect squashes the offered word and leaves the buffer empty after it
  no_valid_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (branch_i || $past(branch_i)) |-> !valid_i)
    else $error("fetch valid high during or right after a redirect");

endmodule

bind prefetch_unit if_stage_assert if_stage_assert_i (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .cyc_i   (wb_cyc_o),
  .stb_i   (wb_stb_o),
  .adr_i   (wb_adr_o),
  .ack_i   (wb_ack_i),
  .err_i   (wb_err_i),
  .branch_i(branch_i),
  .valid_i (fetch_o.valid)
);

//--- test/tb_if_stage.sv
// directed testbench for the fetch stage
// wishbone memory model with random wait states, compare tasks, watchdog
// tests for reset, boot, redirects, handler targets, back-pressure, errors and clear
`timescale 1ns/1ps

module tb_if_stage;

  // memory data is the address xor this pattern
  localparam logic [31:0] MEM_XOR     = 32'hA5C3_0F96;
  localparam logic [31:0] LCG_SEED    = 32'h5e97_e8ae;
  localparam logic [31:0] NO_ERR_ADDR = 32'hFFFF_FFFC;
  // about 45 words at up to 5 cycles each plus the 100-cycle stall test and a wide margin
  localparam int unsigned WATCHDOG_CYCLES = 2000;
  localparam int unsigned WORD_TIMEOUT    = 40;

  typedef struct packed {
    if_pkg::addr_t pc;
    if_pkg::word_t data;
    logic          err;
  } id_word_t;

  logic clk, rst_n;
  if_pkg::addr_t       boot_addr, branch_target, csr_mepc, csr_depc, csr_mtvec;
  if_pkg::addr_t       wb_adr, pc_if, pc_id;
  if_pkg::word_t       wb_dat, instr_rdata;
  if_pkg::pc_sel_e     pc_mux;
  if_pkg::exc_pc_sel_e exc_pc_mux;
  if_pkg::irq_vec_t    irq_vec;
  logic req, wb_cyc, wb_stb, wb_ack, wb_err, instr_valid, instr_new, fetch_err;
  logic pmp_err, instr_valid_clear, pc_set, irq_int, csr_mtvec_init, id_in_ready, if_busy;

  // memory model state
  if_pkg::addr_t bus_err_addr = NO_ERR_ADDR;
  if_pkg::addr_t pmp_addr     = NO_ERR_ADDR;
  logic          pmp_on       = 1'b0;
  logic          serving;
  logic [1:0]    waits;
  logic [31:0]   wait_state;

  id_word_t    seen_q [$];
  int unsigned mismatches = 0;
  int unsigned failures   = 0;

  clk_rst_gen clk_rst_gen_i (.clk_o(clk), .rst_no(rst_n));

  if_stage dut_i (
    .clk_i(clk), .rst_ni(rst_n), .boot_addr_i(boot_addr), .req_i(req),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr), .wb_dat_i(wb_dat),
    .wb_ack_i(wb_ack), .wb_err_i(wb_err),
    .instr_valid_id_o(instr_valid), .instr_new_id_o(instr_new),
    .instr_rdata_id_o(instr_rdata), .instr_fetch_err_o(fetch_err),
    .pc_if_o(pc_if), .pc_id_o(pc_id), .pmp_err_if_i(pmp_err),
    .instr_valid_clear_i(instr_valid_clear), .pc_set_i(pc_set), .pc_mux_i(pc_mux),
    .exc_pc_mux_i(exc_pc_mux), .irq_vec_i(irq_vec), .irq_int_i(irq_int),
    .branch_target_i(branch_target), .csr_mepc_i(csr_mepc), .csr_depc_i(csr_depc),
    .csr_mtvec_i(csr_mtvec), .csr_mtvec_init_o(csr_mtvec_init),
    .id_in_ready_i(id_in_ready), .if_busy_o(if_busy)
  );

  ////////////////////
  // models
  ////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic if_pkg::word_t mem_data(input if_pkg::addr_t a);
    return a ^ MEM_XOR;
  endfunction

  // bus error on one address and pmp fault on another
  function automatic logic expected_err(input if_pkg::addr_t a);
    return (a == bus_err_addr) || (pmp_on && (a == pmp_addr));
  endfunction

  // wishbone slave with 0 to 3 wait states and ack or err for one cycle
  initial begin : wb_memory
    wb_ack     = 1'b0;
    wb_err     = 1'b0;
    wb_dat     = '0;
    serving    = 1'b0;
    waits      = '0;
    wait_state = LCG_SEED;
    forever begin
      @(posedge clk);
      #10;
      wb_ack = 1'b0;
      wb_err = 1'b0;
      if (!rst_n) begin
        serving = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!serving) begin
          serving    = 1'b1;
          wait_state = lcg_step(wait_state);
          waits      = wait_state[29:28];
        end
        if (waits == 2'd0) begin
          wb_dat  = mem_data(wb_adr);
          wb_err  = (wb_adr == bus_err_addr);
          wb_ack  = (wb_adr != bus_err_addr);
          serving = 1'b0;
        end else begin
          waits = waits - 2'd1;
        end
      end
    end
  end

  // pmp fault follows the address offered to ID
  initial begin : pmp_driver
    pmp_err = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      pmp_err = pmp_on && (pc_if == pmp_addr);
    end
  end

  // record every word handed to ID at mid-cycle
  always @(negedge clk) begin
    if (rst_n && instr_new) begin
      seen_q.push_back('{pc: pc_id, data: instr_rdata, err: fetch_err});
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic compare_addr(input string name, input if_pkg::addr_t exp,
                              input if_pkg::addr_t act);
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_word(input string name, input if_pkg::word_t exp,
                              input if_pkg::word_t act);
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic wait_words(input string name, input int unsigned n, output bit ok);
    int unsigned cnt;
    cnt = 0;
    while (seen_q.size() < n && cnt < WORD_TIMEOUT) begin
      step();
      cnt++;
    end
    ok = (seen_q.size() >= n);
    if (!ok) begin
      failures++;
      $display("ERROR %s: no instruction reached ID within %0d cycles", name, WORD_TIMEOUT);
    end
  endtask

  // pop one ID word and check it against the model
  task automatic check_next(input string name, input if_pkg::addr_t pc_exp);
    id_word_t w;
    w = seen_q.pop_front();
    compare_addr({name, " pc"}, pc_exp, w.pc);
    compare_bit({name, " fetch err"}, expected_err(pc_exp), w.err);
    if (pc_exp != bus_err_addr) begin
      compare_word({name, " rdata"}, mem_data(pc_exp), w.data);
    end
  endtask

  task automatic check_stream(input string name, input if_pkg::addr_t start,
                              input int unsigned n);
    bit ok;
    wait_words(name, n, ok);
    if (ok) begin
      for (int unsigned i = 0; i < n; i++) begin
        check_next(name, start + i * if_pkg::INSTR_BYTES);
      end
    end
  endtask

  // one-cycle pc_set and then forget words of the old stream
  task automatic redirect(input if_pkg::pc_sel_e sel, input if_pkg::exc_pc_sel_e exc);
    pc_mux     = sel;
    exc_pc_mux = exc;
    pc_set     = 1'b1;
    step();
    pc_set = 1'b0;
    seen_q.delete();
  endtask

  ////////////////////
  // tests
  ////////////////////

  // outputs right after reset release and before any request
  task automatic reset_test();
    compare_bit("reset cyc", 1'b0, wb_cyc);
    compare_bit("reset stb", 1'b0, wb_stb);
    compare_bit("reset valid", 1'b0, instr_valid);
    compare_bit("reset new", 1'b0, instr_new);
    compare_bit("reset mtvec init", 1'b0, csr_mtvec_init);
    compare_bit("reset busy", 1'b0, if_busy);
  endtask

  task automatic boot_test();
    req    = 1'b1;
    pc_mux = if_pkg::PC_BOOT;
    pc_set = 1'b1;
    #1;
    compare_bit("boot mtvec init", 1'b1, csr_mtvec_init);
    step();
    pc_set = 1'b0;
    #1;
    compare_bit("boot mtvec init end", 1'b0, csr_mtvec_init);
    seen_q.delete();
    // upper boot bits with offset 0x80
    check_stream("boot", 32'h2000_0080, 4);
  endtask

  task automatic redirect_test();
    branch_target = 32'h0000_3000;
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC);
    check_stream("jump", 32'h0000_3000, 3);
    csr_mepc = 32'h0000_5104;
    redirect(if_pkg::PC_ERET, if_pkg::EXC_PC_EXC);
    check_stream("eret", 32'h0000_5104, 3);
    csr_depc = 32'h0000_6208;
    redirect(if_pkg::PC_DRET, if_pkg::EXC_PC_EXC);
    check_stream("dret", 32'h0000_6208, 3);
  endtask

  task automatic exc_target_test();
    // mode bits in the low byte are ignored so the base is 0x4000
    csr_mtvec = 32'h0000_40C1;
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_EXC);
    check_stream("exc base", 32'h0000_4000, 2);
    irq_vec = 5'd5;
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ);
    check_stream("irq vector", 32'h0000_4014, 2);
    irq_int = 1'b1;
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_IRQ);
    check_stream("irq nmi", 32'h0000_407C, 2);
    irq_int = 1'b0;
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_DBD);
    check_stream("debug halt", if_pkg::DM_HALT_ADDR, 2);
    redirect(if_pkg::PC_EXC, if_pkg::EXC_PC_DBG_EXC);
    check_stream("debug exc", if_pkg::DM_EXC_ADDR, 2);
  endtask

  task automatic backpressure_test();
    if_pkg::addr_t exp_pc;
    if_pkg::addr_t held_pc;
    if_pkg::word_t held_data;
    logic [31:0]   rdy_state;
    bit            ok;
    branch_target = 32'h0000_8000;
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC);
    exp_pc    = 32'h0000_8000;
    rdy_state = LCG_SEED;
    held_pc   = pc_id;
    held_data = instr_rdata;
    // random ready for 80 cycles and then a long stall
    for (int i = 0; i < 100; i++) begin
      rdy_state   = lcg_step(rdy_state);
      id_in_ready = (i < 80) ? rdy_state[28] : 1'b0;
      step();
      if (!instr_new) begin
        compare_addr("bp hold pc", held_pc, pc_id);
        compare_word("bp hold rdata", held_data, instr_rdata);
      end
      held_pc   = pc_id;
      held_data = instr_rdata;
      while (seen_q.size() > 0) begin
        check_next("bp sequence", exp_pc);
        exp_pc = exp_pc + if_pkg::INSTR_BYTES;
      end
    end
    // buffer is full and no bus cycle is open
    compare_bit("bp bus idle", 1'b0, wb_cyc);
    compare_bit("bp busy", 1'b1, if_busy);
    // head of the stalled buffer is the next word of the stream
    compare_addr("bp head pc", exp_pc, pc_if);
    id_in_ready = 1'b1;
    wait_words("bp tail", 2, ok);
    if (ok) begin
      while (seen_q.size() > 0) begin
        check_next("bp tail", exp_pc);
        exp_pc = exp_pc + if_pkg::INSTR_BYTES;
      end
    end
  endtask

  task automatic error_clear_test();
    bit ok;
    bus_err_addr  = 32'h0000_9008;
    pmp_addr      = 32'h0000_9010;
    pmp_on        = 1'b1;
    branch_target = 32'h0000_9000;
    redirect(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC);
    check_stream("errors", 32'h0000_9000, 6);
    pmp_on       = 1'b0;
    bus_err_addr = NO_ERR_ADDR;
    // stop the stream and then clear without a new word
    id_in_ready = 1'b0;
    step();
    compare_bit("clear valid before", 1'b1, instr_valid);
    instr_valid_clear = 1'b1;
    step();
    instr_valid_clear = 1'b0;
    compare_bit("clear valid dropped", 1'b0, instr_valid);
    compare_bit("clear no new", 1'b0, instr_new);
    seen_q.delete();
    id_in_ready = 1'b1;
    wait_words("clear refill", 1, ok);
    if (ok) begin
      compare_bit("clear valid again", 1'b1, instr_valid);
    end
  endtask

  initial begin : main
    boot_addr         = 32'h2000_0055;
    req               = 1'b0;
    pc_set            = 1'b0;
    pc_mux            = if_pkg::PC_BOOT;
    exc_pc_mux        = if_pkg::EXC_PC_EXC;
    irq_vec           = '0;
    irq_int           = 1'b0;
    branch_target     = '0;
    csr_mepc          = '0;
    csr_depc          = '0;
    csr_mtvec         = '0;
    id_in_ready       = 1'b1;
    instr_valid_clear = 1'b0;
    wait (rst_n === 1'b1);
    step();
    reset_test();
    boot_test();
    redirect_test();
    exc_target_test();
    backpressure_test();
    error_clear_test();
    $display("checks done: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
